// File: build.f
common/l2_pkg.sv
l2_cache/l2_control.sv
l2_cache/l2_datapath.sv
rtl/evict_buffer.sv
rtl/pmem_arbiter.sv
rtl/l2_cache_top.sv
tb/l2_cache_assertions.sv
tb/tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
# Builds the L2 cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_l2_cache -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_l2_cache > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0

// File: tb/tb_l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache;
	import l2_pkg::*;

	localparam int num_requests = 12;
	localparam int timeout_cycles = num_requests * 40 + 8;

	logic clk;
	logic reset_l2miss;
	line_req_t pmem_req;
	logic pmem_read;
	logic pmem_write;
	logic pmem_resp;
	logic [line_w-1:0] pmem_rdata;
	logic physical_read;
	logic physical_write;
	logic [addr_w-1:0] physical_address;
	logic [line_w-1:0] physical_wdata;
	logic physical_resp;
	logic [line_w-1:0] physical_rdata;
	logic clear_hits;
	logic clear_misses;
	logic [count_w-1:0] miss;
	logic [count_w-1:0] hits;

	int errors;
	logic [count_w-1:0] exp_miss;
	logic [count_w-1:0] exp_hits;
	logic [addr_w-1:0] dirty_addr;
	logic [line_w-1:0] mem [logic [addr_w-1:0]]; // Lines written back by the DUT.
	evict_t wb_log [$];
	logic [addr_w:0] traffic [$]; // Every transfer in order, top bit set for a write.

	// Reference model of memory and of each set's tags, data and ages.
	logic [line_w-1:0] ref_mem [logic [addr_w-1:0]];
	logic ref_valid [num_sets][num_ways];
	logic ref_dirty [num_sets][num_ways];
	logic [tag_w-1:0] ref_tag [num_sets][num_ways];
	logic [lru_w-1:0] ref_age [num_sets][num_ways];
	logic [line_w-1:0] ref_data [num_sets][num_ways];

	l2_cache_top u_l2_cache_top (
		.clk(clk),
		.reset_l2miss(reset_l2miss),
		.pmem_req(pmem_req),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata),
		.physical_read(physical_read),
		.physical_write(physical_write),
		.physical_address(physical_address),
		.physical_wdata(physical_wdata),
		.physical_resp(physical_resp),
		.physical_rdata(physical_rdata),
		.clear_hits(clear_hits),
		.clear_misses(clear_misses),
		.miss(miss),
		.hits(hits)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Untouched memory holds a pattern built from the line address.
	function automatic logic [line_w-1:0] fill_line(input logic [addr_w-1:0] addr);
		logic [line_w-1:0] line;
		for (int k = 0; k < line_w / 32; k++)
			line[k*32 +: 32] = addr ^ (32'h9e37_79b9 * (k + 1));
		return line;
	endfunction

	initial begin : memory_model
		logic [addr_w-1:0] xfer_addr;
		evict_t entry;
		physical_resp = 1'b0;
		physical_rdata = '0;
		forever begin
			@(negedge clk);
			if (physical_read || physical_write) begin
				xfer_addr = physical_address;
				traffic.push_back({physical_write, xfer_addr});
				if (physical_write) begin
					entry.addr = xfer_addr;
					entry.data = physical_wdata;
					mem[xfer_addr] = physical_wdata;
					wb_log.push_back(entry);
				end
				repeat ($urandom_range(4, 1)) @(posedge clk);
				#1;
				physical_rdata = mem.exists(xfer_addr) ? mem[xfer_addr] : fill_line(xfer_addr);
				physical_resp = 1'b1;
				@(posedge clk);
				#1;
				physical_resp = 1'b0;
			end
		end
	end

	task automatic check_line(input string name, input logic [line_w-1:0] got,
			input logic [line_w-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_evict(input string name, input evict_t got, input evict_t exp);
		if (got !== exp) begin
			$display("Error: %s got addr %h data %h expected addr %h data %h",
				name, got.addr, got.data, exp.addr, exp.data);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [count_w-1:0] got,
			input logic [count_w-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_counters();
		check_count("miss", miss, exp_miss);
		check_count("hits", hits, exp_hits);
	endtask

	// Issues one line request, predicts its outcome and checks data and memory traffic.
	task automatic line_access(input logic write, input logic [addr_w-1:0] addr,
			input logic [line_w-1:0] wdata);
		logic [index_w-1:0] s;
		logic [tag_w-1:0] t;
		logic [addr_w-1:0] line_addr;
		logic [lru_w-1:0] hit_age;
		logic do_wb;
		logic [line_w-1:0] got;
		evict_t exp_wb;
		int way;
		int n0;
		int exp_xfers;
		s = addr[offset_w +: index_w];
		t = addr[addr_w-1 -: tag_w];
		line_addr = {addr[addr_w-1:offset_w], {offset_w{1'b0}}};
		way = -1;
		do_wb = 1'b0;
		exp_xfers = 0;
		exp_wb = '0;
		for (int w = 0; w < num_ways; w++)
			if (ref_valid[s][w] && ref_tag[s][w] == t)
				way = w;
		if (way < 0) begin
			for (int w = num_ways - 1; w >= 0; w--)
				if (!ref_valid[s][w])
					way = w;
			if (way < 0)
				for (int w = 0; w < num_ways; w++)
					if (ref_age[s][w] == {lru_w{1'b1}})
						way = w;
			if (ref_valid[s][way] && ref_dirty[s][way]) begin
				do_wb = 1'b1;
				exp_wb.addr = {ref_tag[s][way], s, {offset_w{1'b0}}};
				exp_wb.data = ref_data[s][way];
				ref_mem[exp_wb.addr] = exp_wb.data;
			end
			exp_xfers = do_wb ? 2 : 1;
			ref_valid[s][way] = 1'b1;
			ref_dirty[s][way] = 1'b0;
			ref_tag[s][way] = t;
			ref_data[s][way] = ref_mem.exists(line_addr) ? ref_mem[line_addr] :
				fill_line(line_addr);
			exp_miss = exp_miss + 1'b1;
		end
		hit_age = ref_age[s][way];
		for (int w = 0; w < num_ways; w++)
			if (ref_age[s][w] < hit_age)
				ref_age[s][w] = ref_age[s][w] + 1'b1;
		ref_age[s][way] = '0;
		if (write) begin
			ref_data[s][way] = wdata;
			ref_dirty[s][way] = 1'b1;
		end
		exp_hits = exp_hits + 1'b1; // The closing response of a miss is a hit too.

		n0 = traffic.size();
		pmem_req.addr = addr;
		pmem_req.data = wdata;
		pmem_req.write = write;
		pmem_read = !write;
		pmem_write = write;
		do @(negedge clk); while (!pmem_resp);
		got = pmem_rdata;
		@(posedge clk);
		#1;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		if (!write)
			check_line("pmem_rdata", got, ref_data[s][way]);
		if (traffic.size() - n0 != exp_xfers) begin
			$display("Error: memory transfers got %h expected %h", traffic.size() - n0,
				exp_xfers);
			errors++;
		end else if (exp_xfers > 0) begin
			if (do_wb) begin
				check_evict("write-back", wb_log[wb_log.size()-1], exp_wb);
				if (!traffic[n0][addr_w]) begin
					$display("Refill read reached memory before the write-back");
					errors++;
				end
			end
			if (traffic[traffic.size()-1] !== {1'b0, line_addr}) begin
				$display("Error: physical_address got %h expected %h",
					traffic[traffic.size()-1], {1'b0, line_addr});
				errors++;
			end
		end
	endtask

	task automatic pulse_clear(input logic clear_hit_count);
		if (clear_hit_count)
			clear_hits = 1'b1;
		else
			clear_misses = 1'b1;
		@(posedge clk);
		#1;
		clear_hits = 1'b0;
		clear_misses = 1'b0;
		if (clear_hit_count)
			exp_hits = '0;
		else
			exp_miss = '0;
	endtask

	task automatic cold_miss_read();
		line_access(1'b0, 32'h0000_1020, '0);
		check_counters();
	endtask

	task automatic repeat_read_hit();
		line_access(1'b0, 32'h0000_1020, '0);
		check_counters();
	endtask

	task automatic write_hit_then_read();
		line_access(1'b1, 32'h0000_1020, {8{32'h1234_abcd}});
		line_access(1'b0, 32'h0000_1020, '0);
		check_counters();
	endtask

	// Five tags in set 2; the first is written and ends up as the oldest way.
	task automatic dirty_eviction();
		dirty_addr = {24'h000a00, 3'd2, 5'd0};
		line_access(1'b1, dirty_addr, {8{32'h5a5a_c3c3}});
		for (int i = 1; i < 5; i++)
			line_access(1'b0, {24'(24'h000a00 + i), 3'd2, 5'd0}, '0);
		if (wb_log.size() != 1) begin
			$display("Error: write-back count got %h expected %h", wb_log.size(), 1);
			errors++;
		end
		check_counters();
	endtask

	task automatic evicted_line_reread();
		line_access(1'b0, dirty_addr, '0);
		check_counters();
	endtask

	task automatic counter_clears();
		pulse_clear(1'b1);
		check_counters();
		line_access(1'b0, 32'h0000_1020, '0);
		check_counters();
		pulse_clear(1'b0);
		check_counters();
		line_access(1'b0, 32'h0000_5060, '0);
		check_counters();
	endtask

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("Errors: %0d", errors);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		exp_miss = '0;
		exp_hits = '0;
		dirty_addr = '0;
		void'($urandom(16694));
		reset_l2miss = 1'b1;
		pmem_req = '0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		clear_hits = 1'b0;
		clear_misses = 1'b0;
		for (int s = 0; s < num_sets; s++) begin
			for (int w = 0; w < num_ways; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
				ref_tag[s][w] = '0;
				ref_data[s][w] = '0;
				ref_age[s][w] = lru_w'(w);
			end
		end
		repeat (8) @(posedge clk);
		#1;
		reset_l2miss = 1'b0;
		check_counters();

		cold_miss_read();
		repeat_read_hit();
		write_hit_then_read();
		dirty_eviction();
		evicted_line_reread();
		counter_clears();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/l2_cache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_assertions (
	input logic clk,
	input logic reset_l2miss,
	input logic pmem_resp,
	input logic load_ewb,
	input logic ewb_full,
	input logic refill_read
);

	// A response is a single-cycle pulse.
	resp_pulse: assert property (@(posedge clk) disable iff (reset_l2miss)
		pmem_resp |=> !pmem_resp)
		else $error("pmem_resp stayed high for two cycles");

	load_when_empty: assert property (@(posedge clk) disable iff (reset_l2miss)
		!(load_ewb && ewb_full))
		else $error("load_ewb raised while the eviction buffer is full");

	refill_apart: assert property (@(posedge clk) disable iff (reset_l2miss)
		!(refill_read && load_ewb))
		else $error("refill_read and load_ewb high together");

endmodule

bind l2_control l2_cache_assertions u_l2_cache_assertions (
	.clk(clk),
	.reset_l2miss(reset_l2miss),
	.pmem_resp(pmem_resp),
	.load_ewb(load_ewb),
	.ewb_full(ewb_full),
	.refill_read(refill_read)
);

`default_nettype wire

// File: rtl/l2_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top (
	input logic clk,
	input logic reset_l2miss,
	input l2_pkg::line_req_t pmem_req,
	input logic pmem_read,
	input logic pmem_write,
	output logic pmem_resp,
	output logic [l2_pkg::line_w-1:0] pmem_rdata,
	output logic physical_read,
	output logic physical_write,
	output logic [l2_pkg::addr_w-1:0] physical_address,
	output logic [l2_pkg::line_w-1:0] physical_wdata,
	input logic physical_resp,
	input logic [l2_pkg::line_w-1:0] physical_rdata,
	input logic clear_hits,
	input logic clear_misses,
	output logic [l2_pkg::count_w-1:0] miss,
	output logic [l2_pkg::count_w-1:0] hits
);
	import l2_pkg::*;

	array_ctl_t ctl;
	set_status_t status;
	evict_t victim_line;
	evict_t ewb_entry;
	logic [addr_w-1:0] refill_address;
	logic refill_read;
	logic refill_done;
	logic load_ewb;
	logic ewb_full;
	logic ewb_write;
	logic ewb_done;

	l2_control u_l2_control (
		.clk(clk),
		.reset_l2miss(reset_l2miss),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.status(status),
		.refill_done(refill_done),
		.ewb_full(ewb_full),
		.clear_hits(clear_hits),
		.clear_misses(clear_misses),
		.ctl(ctl),
		.refill_read(refill_read),
		.load_ewb(load_ewb),
		.pmem_resp(pmem_resp),
		.miss(miss),
		.hits(hits)
	);

	l2_datapath u_l2_datapath (
		.clk(clk),
		.reset_l2miss(reset_l2miss),
		.req(pmem_req),
		.ctl(ctl),
		.physical_rdata(physical_rdata),
		.status(status),
		.rdata(pmem_rdata),
		.victim_line(victim_line),
		.refill_address(refill_address)
	);

	evict_buffer u_evict_buffer (
		.clk(clk),
		.reset_l2miss(reset_l2miss),
		.load_ewb(load_ewb),
		.victim_line(victim_line),
		.ewb_done(ewb_done),
		.ewb_full(ewb_full),
		.ewb_write(ewb_write),
		.ewb_entry(ewb_entry)
	);

	pmem_arbiter u_pmem_arbiter (
		.clk(clk),
		.reset_l2miss(reset_l2miss),
		.refill_read(refill_read),
		.refill_address(refill_address),
		.ewb_write(ewb_write),
		.ewb_entry(ewb_entry),
		.physical_resp(physical_resp),
		.physical_read(physical_read),
		.physical_write(physical_write),
		.physical_address(physical_address),
		.physical_wdata(physical_wdata),
		.refill_done(refill_done),
		.ewb_done(ewb_done)
	);

endmodule

`default_nettype wire

// File: rtl/pmem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module pmem_arbiter (
	input logic clk,
	input logic reset_l2miss,
	input logic refill_read,
	input logic [l2_pkg::addr_w-1:0] refill_address,
	input logic ewb_write,
	input l2_pkg::evict_t ewb_entry,
	input logic physical_resp,
	output logic physical_read,
	output logic physical_write,
	output logic [l2_pkg::addr_w-1:0] physical_address,
	output logic [l2_pkg::line_w-1:0] physical_wdata,
	output logic refill_done,
	output logic ewb_done
);

	typedef enum logic [1:0] {own_none, own_refill, own_ewb} owner_t;

	owner_t owner;

	// The write client wins a tie, and an owner keeps the port until its response.
	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss) begin
			owner <= own_none;
		end else if (owner == own_none) begin
			if (ewb_write)
				owner <= own_ewb;
			else if (refill_read)
				owner <= own_refill;
		end else if (physical_resp) begin
			owner <= own_none;
		end
	end

	assign physical_read = (owner == own_refill);
	assign physical_write = (owner == own_ewb);
	assign physical_address = physical_write ? ewb_entry.addr : refill_address;
	assign physical_wdata = ewb_entry.data;
	assign refill_done = physical_resp && (owner == own_refill);
	assign ewb_done = physical_resp && (owner == own_ewb);

endmodule

`default_nettype wire

// File: rtl/evict_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module evict_buffer (
	input logic clk,
	input logic reset_l2miss,
	input logic load_ewb,
	input l2_pkg::evict_t victim_line,
	input logic ewb_done,
	output logic ewb_full,
	output logic ewb_write,
	output l2_pkg::evict_t ewb_entry
);

	logic full;

	// One entry only, so a full buffer asks for its write-back at once.
	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss)
			full <= 1'b0;
		else if (load_ewb)
			full <= 1'b1;
		else if (ewb_done)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load_ewb)
			ewb_entry <= victim_line;
	end

	assign ewb_full = full;
	assign ewb_write = full; // Held until the arbiter reports the write done.

endmodule

`default_nettype wire

// File: l2_cache/l2_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module l2_datapath (
	input logic clk,
	input logic reset_l2miss,
	input l2_pkg::line_req_t req,
	input l2_pkg::array_ctl_t ctl,
	input logic [l2_pkg::line_w-1:0] physical_rdata,
	output l2_pkg::set_status_t status,
	output logic [l2_pkg::line_w-1:0] rdata,
	output l2_pkg::evict_t victim_line,
	output logic [l2_pkg::addr_w-1:0] refill_address
);
	import l2_pkg::*;

	logic [tag_w-1:0] tag_arr [num_ways][num_sets];
	logic [line_w-1:0] data_arr [num_ways][num_sets];
	way_vec_t valid_arr [num_sets];
	way_vec_t dirty_arr [num_sets];
	lru_ages_t lru_arr [num_sets];

	logic [index_w-1:0] idx;
	logic [tag_w-1:0] tag;
	logic [line_w-1:0] wdata;
	way_vec_t hit_vec;

	assign idx = req.addr[offset_w +: index_w];
	assign tag = req.addr[addr_w-1 -: tag_w];
	assign wdata = ctl.fill_sel ? physical_rdata : req.data;

	always_comb begin
		rdata = '0;
		for (int w = 0; w < num_ways; w++) begin
			hit_vec[w] = valid_arr[idx][w] && (tag_arr[w][idx] == tag);
			if (hit_vec[w])
				rdata = data_arr[w][idx];
		end
	end

	assign status.hit = hit_vec;
	assign status.valid = valid_arr[idx];
	assign status.dirty = dirty_arr[idx];
	assign status.lru = lru_arr[idx];

	// The victim is rebuilt from its stored tag and the current index.
	assign victim_line.addr = {tag_arr[ctl.victim][idx], idx, {offset_w{1'b0}}};
	assign victim_line.data = data_arr[ctl.victim][idx];
	assign refill_address = {req.addr[addr_w-1:offset_w], {offset_w{1'b0}}};

	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (ctl.data_write[w])
				data_arr[w][idx] <= wdata;
			if (ctl.tag_write[w])
				tag_arr[w][idx] <= tag;
		end
	end

	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_arr[s] <= '0;
				dirty_arr[s] <= '0;
				for (int w = 0; w < num_ways; w++)
					lru_arr[s][w] <= lru_w'(w); // Way 3 starts as the oldest.
			end
		end else begin
			for (int w = 0; w < num_ways; w++) begin
				if (ctl.valid_write[w])
					valid_arr[idx][w] <= 1'b1;
				if (ctl.dirty_write[w])
					dirty_arr[idx][w] <= ctl.dirty_val;
				if (ctl.lru_write[w])
					lru_arr[idx][w] <= hit_vec[w] ? '0 : lru_arr[idx][w] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: l2_cache/l2_control.sv
`timescale 1ns/1ps
`default_nettype none

module l2_control (
	input logic clk,
	input logic reset_l2miss,
	input logic pmem_read,
	input logic pmem_write,
	input l2_pkg::set_status_t status,
	input logic refill_done,
	input logic ewb_full,
	input logic clear_hits,
	input logic clear_misses,
	output l2_pkg::array_ctl_t ctl,
	output logic refill_read,
	output logic load_ewb,
	output logic pmem_resp,
	output logic [l2_pkg::count_w-1:0] miss,
	output logic [l2_pkg::count_w-1:0] hits
);
	import l2_pkg::*;

	typedef enum logic [1:0] {idle, evict, refill} state_t;

	state_t state, next_state;
	logic resp_q; // The pmem side still holds the old request in the cycle after a response.
	logic req_seen;
	logic hit;
	logic [lru_w-1:0] hit_age;
	logic [1:0] victim;

	assign req_seen = (pmem_read | pmem_write) & ~resp_q;
	assign hit = |status.hit;

	// The first invalid way wins, otherwise the oldest way.
	always_comb begin
		victim = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (status.lru[w] == lru_w'(num_ways - 1))
				victim = 2'(w);
		end
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!status.valid[w])
				victim = 2'(w);
		end
	end

	always_comb begin
		hit_age = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (status.hit[w])
				hit_age = status.lru[w];
		end
	end

	always_comb begin
		next_state = state;
		ctl = '0;
		ctl.victim = victim;
		refill_read = 1'b0;
		load_ewb = 1'b0;
		pmem_resp = 1'b0;
		case (state)
			idle: begin
				if (req_seen && hit) begin
					pmem_resp = 1'b1;
					// Only the hit way and the ways younger than it change age.
					for (int w = 0; w < num_ways; w++)
						ctl.lru_write[w] = status.hit[w] | (status.lru[w] < hit_age);
					if (pmem_write) begin
						ctl.data_write = status.hit;
						ctl.dirty_write = status.hit;
						ctl.dirty_val = 1'b1;
					end
				end else if (req_seen) begin
					if (&status.valid && status.dirty[victim])
						next_state = evict;
					else
						next_state = refill;
				end
			end
			evict: begin
				if (!ewb_full) begin
					load_ewb = 1'b1; // The victim line is captured on this edge.
					next_state = refill;
				end
			end
			refill: begin
				refill_read = 1'b1;
				if (refill_done) begin
					ctl.fill_sel = 1'b1;
					ctl.data_write[victim] = 1'b1;
					ctl.tag_write[victim] = 1'b1;
					ctl.valid_write[victim] = 1'b1;
					ctl.dirty_write[victim] = 1'b1; // A fresh line is clean.
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss) begin
			state <= idle;
			resp_q <= 1'b0;
		end else begin
			state <= next_state;
			resp_q <= pmem_resp;
		end
	end

	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss)
			miss <= '0;
		else if (clear_misses)
			miss <= '0;
		else if (refill_done)
			miss <= miss + 1'b1;
	end

	// Every response comes from a hit, so each one counts once.
	always_ff @(posedge clk or posedge reset_l2miss) begin
		if (reset_l2miss)
			hits <= '0;
		else if (clear_hits)
			hits <= '0;
		else if (pmem_resp)
			hits <= hits + 1'b1;
	end

endmodule

`default_nettype wire

// File: common/l2_pkg.sv
`default_nettype none

package l2_pkg;

	localparam int addr_w = 32;
	localparam int line_w = 256;
	localparam int num_ways = 4;
	localparam int num_sets = 8;
	localparam int offset_w = 5;
	localparam int index_w = 3;
	localparam int tag_w = 24;
	localparam int lru_w = 2; // Age 3 marks the least recently used way.
	localparam int count_w = 16;

	typedef logic [num_ways-1:0] way_vec_t;
	typedef logic [num_ways-1:0][lru_w-1:0] lru_ages_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [line_w-1:0] data;
		logic write;
	} line_req_t;

	// Array commands from the controller, applied on the next clock edge.
	typedef struct packed {
		way_vec_t data_write;
		way_vec_t tag_write;
		way_vec_t valid_write;
		way_vec_t dirty_write;
		way_vec_t lru_write;
		logic dirty_val;
		logic fill_sel; // Set to write the memory line instead of the request line.
		logic [1:0] victim;
	} array_ctl_t;

	typedef struct packed {
		way_vec_t hit;
		way_vec_t valid;
		way_vec_t dirty;
		lru_ages_t lru;
	} set_status_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [line_w-1:0] data;
	} evict_t;

endpackage

`default_nettype wire
